/* hdl/tlb_pkg.sv */
// Shared widths, set geometry and payload structs for the set-associative TLB
// Every TLB module takes these definitions with a wildcard import in its header

package tlb_pkg;

    // ============================================================
    // Page and set geometry
    // ============================================================

    // Virtual and physical page number widths
    localparam int VA_PAGE_BITS = 20;
    localparam int PA_PAGE_BITS = 16;

    // Low page bits pick the set and the rest of the page number is the tag
    localparam int SET_IDX_BITS = 6;
    localparam int NUM_SETS = 1 << SET_IDX_BITS;
    localparam int VA_TAG_BITS = VA_PAGE_BITS - SET_IDX_BITS;

    // Cycles from an accepted lookup to its response
    localparam int LOOKUP_LATENCY = 5;

    // Idle cycles the fill FSM waits after each insert
    localparam int FILL_BUBBLE_CYCLES = 4;

    typedef logic [VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [PA_PAGE_BITS-1:0] t_pa_page;
    typedef logic [SET_IDX_BITS-1:0] t_set_idx;
    typedef logic [VA_TAG_BITS-1:0] t_va_tag;

    // ============================================================
    // Entries, requests and responses
    // ============================================================

    // One translation as held in a way, 31 bits wide
    typedef struct packed
    {
        logic valid;
        t_va_tag tag;
        t_pa_page pa;
    } t_tlb_entry;

    typedef struct packed
    {
        t_va_page va;
    } t_lookup_req;

    // Exactly one of hit and miss is set, pa only means something on a hit
    typedef struct packed
    {
        logic hit;
        logic miss;
        t_va_page va;
        t_pa_page pa;
    } t_lookup_rsp;

    typedef struct packed
    {
        t_va_page va;
        t_pa_page pa;
    } t_fill_req;

    // Way select travels beside this since its width follows the associativity
    typedef struct packed
    {
        t_set_idx set;
        t_tlb_entry entry;
    } t_way_write;

    typedef enum logic [1:0]
    {
        FILL_IDLE,
        FILL_PICK,
        FILL_INSERT,
        FILL_BUBBLE
    } t_fill_state;

    // Set index is the low slice of the page number
    function automatic t_set_idx va_set(t_va_page va);
        return va[SET_IDX_BITS-1:0];
    endfunction

    // Tag is whatever remains above the set index
    function automatic t_va_tag va_tag(t_va_page va);
        return va[VA_PAGE_BITS-1:SET_IDX_BITS];
    endfunction

endpackage

/* hdl/tlb_way_store.sv */
// Entry storage for the TLB with one memory per way
// A read takes rd_set in one cycle and presents every way two cycles later
// Reset and inval start a sweep that writes invalid entries to all sets

`timescale 1ns/10ps

module tlb_way_store
    import tlb_pkg::*;
#(
    parameter int NUM_WAYS = 4
)
(
    input  logic clk,
    input  logic reset,
    input  logic inval,

    // Read port used by the lookup pipeline
    input  t_set_idx rd_set,
    output t_tlb_entry [NUM_WAYS-1:0] rd_entries,

    // Write port used by the fill FSM
    input  t_way_write way_wr,
    input  logic [NUM_WAYS-1:0] way_wen,

    output logic ready
);

    // ============================================================
    // Clearing sweep
    // ============================================================

    // High while the sweep walks the sets
    logic sweep_active;

    // Set being cleared in this cycle
    t_set_idx sweep_idx;

    always_ff @(posedge clk)
    begin
        if (reset || inval)
        begin
            // Restart the walk from set zero
            sweep_active <= 1'b1;
            sweep_idx <= '0;
        end
        else if (sweep_active)
        begin
            sweep_idx <= sweep_idx + 1'b1;

            // The last set is cleared in this cycle
            if (sweep_idx == t_set_idx'(NUM_SETS - 1))
            begin
                sweep_active <= 1'b0;
            end
        end
    end

    // Lookups and fills wait until every set is invalid
    assign ready = !sweep_active;

    // ============================================================
    // Per-way memories
    // ============================================================

    // Separate memories let a fill touch one way without a read-modify-write
    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        t_tlb_entry mem [NUM_SETS];

        // First read register, then the output register
        t_tlb_entry rd_q1;
        t_tlb_entry rd_q2;

        always_ff @(posedge clk)
        begin
            // The sweep owns the write port until it finishes
            if (sweep_active)
            begin
                mem[sweep_idx] <= '0;
            end
            else if (way_wen[w])
            begin
                mem[way_wr.set] <= way_wr.entry;
            end

            rd_q1 <= mem[rd_set];
            rd_q2 <= rd_q1;
        end

        assign rd_entries[w] = rd_q2;
    end

endmodule

/* hdl/tlb_lookup_pipe.sv */
// Five-stage lookup pipeline of the TLB
// Stage 0 reads the set, stage 2 XORs tags, stage 3 reduces the XOR
// and stage 4 picks the hit way and registers the response
// Responses leave in request order with no way to stall them

`timescale 1ns/10ps

module tlb_lookup_pipe
    import tlb_pkg::*;
#(
    parameter int NUM_WAYS = 4
)
(
    input  logic clk,
    input  logic reset,

    input  logic lookup_valid,
    input  t_lookup_req lookup_req,
    input  logic lookup_ready,

    // Set read toward the way store and the returned ways
    output t_set_idx rd_set,
    input  t_tlb_entry [NUM_WAYS-1:0] rd_entries,

    output logic rsp_valid,
    output t_lookup_rsp rsp
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);

    // State carried alongside every request
    typedef struct packed
    {
        logic did_lookup;
        t_va_page va;
    } t_stage;

    // Stage register s holds what stage s works on
    t_stage stg [1:LOOKUP_LATENCY];

    // ============================================================
    // Stage 0 and the request state pipeline
    // ============================================================

    // The set read starts in the accept cycle
    assign rd_set = va_set(lookup_req.va);

    always_ff @(posedge clk)
    begin
        // The page number rides along beside the lookup flag
        stg[1].va <= lookup_req.va;
        for (int s = 1; s < LOOKUP_LATENCY; s++)
        begin
            stg[s+1].va <= stg[s].va;
        end

        if (reset)
        begin
            for (int s = 1; s <= LOOKUP_LATENCY; s++)
            begin
                stg[s].did_lookup <= 1'b0;
            end
        end
        else
        begin
            stg[1].did_lookup <= lookup_valid && lookup_ready;
            for (int s = 1; s < LOOKUP_LATENCY; s++)
            begin
                stg[s+1].did_lookup <= stg[s].did_lookup;
            end
        end
    end

    // Stage 1 only waits for the registered memory read

    // ============================================================
    // Stage 2 does the first half of the tag compare
    // ============================================================

    // Per-way tag XOR that is all zeros when the tags agree
    t_va_tag [NUM_WAYS-1:0] stg3_xor;
    t_pa_page [NUM_WAYS-1:0] stg3_pa;

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            // An invalid entry gets all ones so it can never match
            if (rd_entries[w].valid)
            begin
                stg3_xor[w] <= rd_entries[w].tag ^ va_tag(stg[2].va);
            end
            else
            begin
                stg3_xor[w] <= '1;
            end

            stg3_pa[w] <= rd_entries[w].pa;
        end
    end

    // ============================================================
    // Stage 3 reduces each XOR to a match bit
    // ============================================================

    logic [NUM_WAYS-1:0] stg4_match;
    t_pa_page [NUM_WAYS-1:0] stg4_pa;

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            stg4_match[w] <= ~(|stg3_xor[w]);
        end

        stg4_pa <= stg3_pa;
    end

    // ============================================================
    // Stage 4 selects the way and registers the response
    // ============================================================

    logic stg4_hit;
    logic [WAY_BITS-1:0] stg4_way;

    always_comb
    begin
        stg4_hit = |stg4_match;

        // Walk down from the top so the lowest matching way wins
        stg4_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (stg4_match[w])
            begin
                stg4_way = WAY_BITS'(w);
            end
        end
    end

    logic rsp_hit;
    logic rsp_miss;
    t_pa_page rsp_pa;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_hit <= 1'b0;
            rsp_miss <= 1'b0;
        end
        else
        begin
            rsp_hit <= stg[4].did_lookup && stg4_hit;
            rsp_miss <= stg[4].did_lookup && !stg4_hit;
        end

        // On a miss this is whatever way zero held
        rsp_pa <= stg4_pa[stg4_way];
    end

    // The last stage register lines up with the response register
    assign rsp_valid = stg[LOOKUP_LATENCY].did_lookup;

    always_comb
    begin
        rsp.hit = rsp_hit;
        rsp.miss = rsp_miss;
        rsp.va = stg[LOOKUP_LATENCY].va;
        rsp.pa = rsp_pa;
    end

endmodule

/* hdl/tlb_fill_ctrl.sv */
// Fill FSM of the TLB that turns page walker fills into way writes
// Victim is the lowest empty way of the set, else an LFSR-chosen way
// Each insert is followed by a fixed bubble before the next fill is taken

`timescale 1ns/10ps

module tlb_fill_ctrl
    import tlb_pkg::*;
#(
    parameter int NUM_WAYS = 4
)
(
    input  logic clk,
    input  logic reset,
    input  logic inval,
    input  logic store_ready,

    input  logic fill_valid,
    input  t_fill_req fill_req,
    output logic fill_ready,

    // Write toward the way store, way_wen is one-hot during an insert
    output t_way_write way_wr,
    output logic [NUM_WAYS-1:0] way_wen
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam int BUBBLE_BITS = $clog2(FILL_BUBBLE_CYCLES + 1);

    t_fill_state state;
    logic [BUBBLE_BITS-1:0] bubble_cnt;

    // Fill being inserted, held from acceptance until the next one
    t_fill_req fill_q;

    // One-hot victim picked in FILL_PICK
    logic [NUM_WAYS-1:0] victim_oh;

    // One bit per way of every set, set when the way holds an entry
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] occ;

    // Free-running LFSR for victims in full sets
    logic [15:0] lfsr;

    // ============================================================
    // Fill FSM
    // ============================================================

    // Only idle takes a fill, and never during a clearing sweep
    assign fill_ready = (state == FILL_IDLE) && store_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= FILL_IDLE;
            bubble_cnt <= '0;
        end
        else
        begin
            case (state)
                FILL_IDLE:
                begin
                    if (fill_valid && fill_ready)
                    begin
                        state <= FILL_PICK;
                    end
                end
                FILL_PICK:
                begin
                    state <= FILL_INSERT;
                end
                FILL_INSERT:
                begin
                    state <= FILL_BUBBLE;
                    bubble_cnt <= '0;
                end
                FILL_BUBBLE:
                begin
                    // Hold off new fills for a fixed number of cycles
                    bubble_cnt <= bubble_cnt + 1'b1;
                    if (bubble_cnt == BUBBLE_BITS'(FILL_BUBBLE_CYCLES - 1))
                    begin
                        state <= FILL_IDLE;
                    end
                end
                default:
                begin
                    state <= FILL_IDLE;
                end
            endcase
        end

        // Capture the request when it is taken
        if (state == FILL_IDLE && fill_valid && fill_ready)
        begin
            fill_q <= fill_req;
        end
    end

    // ============================================================
    // Victim choice and occupancy
    // ============================================================

    // Taps 16, 14, 13 and 11 give a maximal length sequence
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lfsr <= 16'hace1;
        end
        else
        begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    logic [NUM_WAYS-1:0] set_occ;
    logic [NUM_WAYS-1:0] pick_oh;

    always_comb
    begin
        set_occ = occ[va_set(fill_q.va)];

        // A full set falls back to the random way
        pick_oh = NUM_WAYS'(1) << lfsr[WAY_BITS-1:0];

        // Downward walk leaves the lowest empty way chosen
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!set_occ[w])
            begin
                pick_oh = NUM_WAYS'(1) << w;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == FILL_PICK)
        begin
            victim_oh <= pick_oh;
        end

        // Clearing wins over an insert in the same cycle
        if (reset || inval)
        begin
            occ <= '0;
        end
        else if (state == FILL_INSERT)
        begin
            occ[va_set(fill_q.va)] <= set_occ | victim_oh;
        end
    end

    // Write data is always the held fill, only the enable marks the insert
    always_comb
    begin
        way_wr.set = va_set(fill_q.va);
        way_wr.entry.valid = 1'b1;
        way_wr.entry.tag = va_tag(fill_q.va);
        way_wr.entry.pa = fill_q.pa;
        way_wen = (state == FILL_INSERT) ? victim_oh : '0;
    end

endmodule

/* hdl/tlb_top.sv */
// Top level of the set-associative TLB with one pipelined lookup port
// The fill port takes translations from a page walker, inval clears everything
// NUM_WAYS sets the associativity and is handed down to every submodule

`timescale 1ns/10ps

module tlb_top
    import tlb_pkg::*;
#(
    parameter int NUM_WAYS = 4
)
(
    input  logic clk,
    input  logic reset,
    input  logic inval,

    // Lookup request, one per cycle while ready is high
    input  logic lookup_valid,
    input  t_lookup_req lookup_req,
    output logic lookup_ready,

    // Lookup response, no back-pressure
    output logic rsp_valid,
    output t_lookup_rsp rsp,

    // Fill request from the page walker
    input  logic fill_valid,
    input  t_fill_req fill_req,
    output logic fill_ready
);

    // Read address goes out in the accept cycle
    t_set_idx rd_set;

    // All ways of the addressed set, two cycles after rd_set
    t_tlb_entry [NUM_WAYS-1:0] rd_entries;

    // Write port shared by every way, the enable picks one
    t_way_write way_wr;
    logic [NUM_WAYS-1:0] way_wen;

    // ============================================================
    // Entry storage
    // ============================================================

    // Store ready is the lookup ready, low during any clearing sweep
    tlb_way_store #(
        .NUM_WAYS(NUM_WAYS)
    ) way_store (
        .clk(clk),
        .reset(reset),
        .inval(inval),
        .rd_set(rd_set),
        .rd_entries(rd_entries),
        .way_wr(way_wr),
        .way_wen(way_wen),
        .ready(lookup_ready)
    );

    // ============================================================
    // Lookup and fill paths
    // ============================================================

    tlb_lookup_pipe #(
        .NUM_WAYS(NUM_WAYS)
    ) lookup_pipe (
        .clk(clk),
        .reset(reset),
        .lookup_valid(lookup_valid),
        .lookup_req(lookup_req),
        .lookup_ready(lookup_ready),
        .rd_set(rd_set),
        .rd_entries(rd_entries),
        .rsp_valid(rsp_valid),
        .rsp(rsp)
    );

    // The fill FSM also holds off while the store is sweeping
    tlb_fill_ctrl #(
        .NUM_WAYS(NUM_WAYS)
    ) fill_ctrl (
        .clk(clk),
        .reset(reset),
        .inval(inval),
        .store_ready(lookup_ready),
        .fill_valid(fill_valid),
        .fill_req(fill_req),
        .fill_ready(fill_ready),
        .way_wr(way_wr),
        .way_wen(way_wen)
    );

endmodule

/* bench/tlb_tb.sv */
// Self-checking testbench for the set-associative TLB
// Drives lookups, fills and inval into tlb_top and checks every response
// against a VA to PA model kept in queues and prints one line per test

`timescale 1ns/10ps

module tlb_tb
    import tlb_pkg::*;
();

    // Expected outcome of a lookup where EITHER covers a possibly evicted entry
    localparam int EXP_MISS = 0;
    localparam int EXP_HIT = 1;
    localparam int EXP_EITHER = 2;

    logic clk;
    logic reset;
    logic inval;
    logic lookup_valid;
    t_lookup_req lookup_req;
    logic lookup_ready;
    logic rsp_valid;
    t_lookup_rsp rsp;
    logic fill_valid;
    t_fill_req fill_req;
    logic fill_ready;

    integer seed;
    logic timed_out;
    int err_count;
    int test_err_base;
    int pass_tests;
    int fail_tests;
    int cycle_no;

    // Reference model where state 1 means present and 2 means maybe evicted
    t_va_page model_va[$];
    t_pa_page model_pa[$];
    int model_state[$];

    // Outstanding lookups in request order
    t_va_page exp_va[$];
    t_pa_page exp_pa[$];
    int exp_kind[$];
    int exp_cycle[$];

    // Results of lookups whose outcome was not known in advance
    t_va_page open_va[$];
    logic open_hit[$];

    // Shared between tests 2 to 4
    t_set_idx fill_set;
    t_va_page set_va[$];

    t_va_page mon_va;
    t_pa_page mon_pa;
    int mon_kind;
    int mon_cycle;
    int mon_idx;

    tlb_top #(
        .NUM_WAYS(4)
    ) uut (
        .clk(clk),
        .reset(reset),
        .inval(inval),
        .lookup_valid(lookup_valid),
        .lookup_req(lookup_req),
        .lookup_ready(lookup_ready),
        .rsp_valid(rsp_valid),
        .rsp(rsp),
        .fill_valid(fill_valid),
        .fill_req(fill_req),
        .fill_ready(fill_ready)
    );

    always #4 clk = ~clk;

    function automatic int find_model(input t_va_page va);
        for (int i = 0; i < model_va.size(); i++)
        begin
            if (model_va[i] == va)
            begin
                return i;
            end
        end
        return -1;
    endfunction

    // ============================================================
    // Response monitor
    // ============================================================

    // Responses are checked before new lookups are queued in the same edge
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (rsp_valid === 1'b1)
            begin
                assert (exp_va.size() != 0)
                else
                begin
                    $display("ERR %0t: response with no lookup outstanding", $time);
                    err_count++;
                end
                if (exp_va.size() != 0)
                begin
                    mon_va = exp_va.pop_front();
                    mon_pa = exp_pa.pop_front();
                    mon_kind = exp_kind.pop_front();
                    mon_cycle = exp_cycle.pop_front();
                    assert (cycle_no - mon_cycle == LOOKUP_LATENCY)
                    else
                    begin
                        $display("ERR %0t: latency %0d", $time, cycle_no - mon_cycle);
                        err_count++;
                    end
                    assert ((rsp.hit ^ rsp.miss) === 1'b1 && rsp.va === mon_va)
                    else
                    begin
                        $display("ERR %0t: bad flags or va %h for %h", $time, rsp.va, mon_va);
                        err_count++;
                    end
                    assert (mon_kind != EXP_MISS || rsp.miss === 1'b1)
                    else
                    begin
                        $display("ERR %0t: va %h should miss", $time, mon_va);
                        err_count++;
                    end
                    assert (mon_kind != EXP_HIT || rsp.hit === 1'b1)
                    else
                    begin
                        $display("ERR %0t: va %h should hit", $time, mon_va);
                        err_count++;
                    end
                    // A hit has to carry the model's PA whatever was expected
                    assert (rsp.hit !== 1'b1 || rsp.pa === mon_pa)
                    else
                    begin
                        $display("ERR %0t: pa %h, model has %h", $time, rsp.pa, mon_pa);
                        err_count++;
                    end
                    if (mon_kind == EXP_EITHER)
                    begin
                        open_va.push_back(mon_va);
                        open_hit.push_back(rsp.hit);
                    end
                end
            end
            if (lookup_valid && lookup_ready)
            begin
                mon_idx = find_model(lookup_req.va);
                exp_va.push_back(lookup_req.va);
                exp_cycle.push_back(cycle_no);
                if (mon_idx < 0)
                begin
                    exp_kind.push_back(EXP_MISS);
                    exp_pa.push_back('0);
                end
                else
                begin
                    exp_kind.push_back(model_state[mon_idx] == 1 ? EXP_HIT : EXP_EITHER);
                    exp_pa.push_back(model_pa[mon_idx]);
                end
            end
        end
        cycle_no++;
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================

    // Inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_lookup_ready(input int limit, output int cycles);
        cycles = 0;
        while (lookup_ready !== 1'b1 && cycles < limit)
        begin
            step_cycle();
            cycles++;
        end
        if (lookup_ready !== 1'b1)
        begin
            $display("Timed out at %0t waiting for lookup_ready", $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_fill_ready(input int limit, output int cycles);
        cycles = 0;
        while (fill_ready !== 1'b1 && cycles < limit)
        begin
            step_cycle();
            cycles++;
        end
        if (fill_ready !== 1'b1)
        begin
            $display("Timed out at %0t waiting for fill_ready", $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (exp_va.size() != 0 && cycles < limit)
        begin
            step_cycle();
            cycles++;
        end
        if (exp_va.size() != 0)
        begin
            $display("Timed out at %0t waiting for %0d responses", $time, exp_va.size());
            timed_out = 1'b1;
        end
    endtask

    // Back-to-back calls keep lookup_valid high for one request per cycle
    task automatic issue_lookup(input t_va_page va);
        int n;
        wait_lookup_ready(20, n);
        if (timed_out)
        begin
            return;
        end
        lookup_valid = 1'b1;
        lookup_req.va = va;
        step_cycle();
        lookup_valid = 1'b0;
    endtask

    task automatic do_fill(input t_va_page va, input t_pa_page pa);
        int n;
        wait_fill_ready(20, n);
        if (timed_out)
        begin
            return;
        end
        fill_valid = 1'b1;
        fill_req.va = va;
        fill_req.pa = pa;
        step_cycle();
        fill_valid = 1'b0;
        wait_fill_ready(20, n);
        if (timed_out)
        begin
            return;
        end
        // Pick, insert and the bubble keep the port closed
        assert (n == 2 + FILL_BUBBLE_CYCLES)
        else
        begin
            $display("ERR %0t: fill_ready low for %0d cycles", $time, n);
            err_count++;
        end
        model_va.push_back(va);
        model_pa.push_back(pa);
        model_state.push_back(1);
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_err_base && !timed_out)
        begin
            pass_tests++;
            $display("%s: ok", name);
        end
        else
        begin
            fail_tests++;
            $display("%s: failed with %0d errors", name, err_count - test_err_base);
        end
        test_err_base = err_count;
    endtask

    // ============================================================
    // Tests
    // ============================================================

    task automatic test_cold_misses();
        int n;
        assert (lookup_ready === 1'b0 && fill_ready === 1'b0 && rsp_valid === 1'b0)
        else
        begin
            $display("ERR %0t: outputs not low after reset", $time);
            err_count++;
        end
        wait_lookup_ready(NUM_SETS + 10, n);
        if (timed_out)
        begin
            return;
        end
        assert (fill_ready === 1'b1)
        else
        begin
            $display("ERR %0t: fill_ready low after the sweep", $time);
            err_count++;
        end
        for (int i = 0; i < 8; i++)
        begin
            issue_lookup(t_va_page'($random(seed)));
        end
        wait_drain(20);
    endtask

    task automatic test_single_fill();
        t_va_page va;
        va = t_va_page'($random(seed));
        fill_set = va[SET_IDX_BITS-1:0];
        do_fill(va, t_pa_page'($random(seed)));
        issue_lookup(va);
        // Same set with one tag bit flipped
        issue_lookup(va ^ (t_va_page'(1) << SET_IDX_BITS));
        wait_drain(20);
    endtask

    task automatic test_full_set();
        t_va_tag tag_base;
        tag_base = t_va_tag'($random(seed));
        fill_set = fill_set + 1'b1;
        for (int i = 0; i < 5; i++)
        begin
            set_va.push_back({t_va_tag'(tag_base + i), fill_set});
        end
        for (int i = 0; i < 4; i++)
        begin
            do_fill(set_va[i], t_pa_page'($random(seed)));
        end
        for (int i = 0; i < 4; i++)
        begin
            issue_lookup(set_va[i]);
        end
        wait_drain(20);
    endtask

    task automatic test_eviction();
        int misses;
        int idx;
        // Any of the four older entries may be the victim
        for (int i = 0; i < 4; i++)
        begin
            model_state[find_model(set_va[i])] = 2;
        end
        open_va.delete();
        open_hit.delete();
        do_fill(set_va[4], t_pa_page'($random(seed)));
        for (int i = 0; i < 5; i++)
        begin
            issue_lookup(set_va[i]);
        end
        wait_drain(20);
        misses = 0;
        for (int i = 0; i < open_va.size(); i++)
        begin
            idx = find_model(open_va[i]);
            if (open_hit[i])
            begin
                model_state[idx] = 1;
            end
            else
            begin
                misses++;
                model_va.delete(idx);
                model_pa.delete(idx);
                model_state.delete(idx);
            end
        end
        assert (open_va.size() == 4 && misses == 1)
        else
        begin
            $display("ERR %0t: %0d of %0d older entries missed", $time, misses, open_va.size());
            err_count++;
        end
    endtask

    task automatic test_invalidate();
        int n;
        t_va_page old_va[$];
        inval = 1'b1;
        step_cycle();
        inval = 1'b0;
        assert (lookup_ready === 1'b0 && fill_ready === 1'b0)
        else
        begin
            $display("ERR %0t: ready still high after inval", $time);
            err_count++;
        end
        wait_lookup_ready(NUM_SETS + 10, n);
        if (timed_out)
        begin
            return;
        end
        // Everything that hit before is gone
        old_va = model_va;
        model_va.delete();
        model_pa.delete();
        model_state.delete();
        for (int i = 0; i < old_va.size(); i++)
        begin
            issue_lookup(old_va[i]);
        end
        wait_drain(20);
    endtask

    initial
    begin
        seed = 96564;
        clk = 1'b0;
        reset = 1'b1;
        inval = 1'b0;
        lookup_valid = 1'b0;
        lookup_req = '0;
        fill_valid = 1'b0;
        fill_req = '0;
        timed_out = 1'b0;
        err_count = 0;
        test_err_base = 0;
        pass_tests = 0;
        fail_tests = 0;
        cycle_no = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        test_cold_misses();
        finish_test("reset and cold misses");
        if (!timed_out)
        begin
            test_single_fill();
            finish_test("single fill");
        end
        if (!timed_out)
        begin
            test_full_set();
            finish_test("four ways in one set");
        end
        if (!timed_out)
        begin
            test_eviction();
            finish_test("eviction from a full set");
        end
        if (!timed_out)
        begin
            test_invalidate();
            finish_test("invalidate");
        end

        $display("Tests ok: %0d, tests failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && err_count == 0 && !timed_out)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/tlb_pkg.sv
hdl/tlb_way_store.sv
hdl/tlb_lookup_pipe.sv
hdl/tlb_fill_ctrl.sv
hdl/tlb_top.sv
bench/tlb_tb.sv
